// File: Bender.yml
package:
  name: mem_system

sources:
  - files:
      - logic/mem_pkg.sv
      - logic/bus_arbiter.sv
      - logic/icache.sv
      - logic/dcache.sv
      - logic/block_ram.sv
      - logic/mem_system.sv
  - target: test
    files:
      - tb/mem_system_checker.sv
      - tb/tb_mem_system.sv

// File: logic/block_ram.sv
`timescale 1ns/1ps

module block_ram (
	input  logic              clk,
	input  mem_pkg::bus_req_t req,
	output mem_pkg::bus_rsp_t rsp
);

	mem_pkg::word_t                 mem [mem_pkg::ram_words];
	logic [mem_pkg::ram_addr_w-1:0] waddr;

	assign waddr = req.addr[mem_pkg::ram_addr_w+1:2];

	always_ff @(posedge clk)
	begin
		if (req.wr)
		begin
			mem[waddr] <= req.wdata;
		end
	end

	// Answer exactly one cycle after any strobe
	always_ff @(posedge clk)
	begin
		rsp.ready <= req.rd || req.wr;
		if (req.rd)
		begin
			rsp.rdata <= mem[waddr];
		end
		else
		begin
			rsp.rdata <= '0;                      // Keeps the wired-OR merge clean
		end
	end

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input  logic            clk,
	input  logic            arst_n,
	input  mem_pkg::grant_t req,
	output mem_pkg::grant_t ack
);

	mem_pkg::grant_t pick;
	mem_pkg::grant_t ack_next;

	// Lowest index among the active requesters
	always_comb
	begin
		pick = '0;
		for (int i = mem_pkg::num_masters - 1; i >= 0; i--)
		begin
			if (req[i])
			begin
				pick = mem_pkg::grant_t'(1) << i;
			end
		end
	end

	// The owner keeps the bus until its request falls
	always_comb
	begin
		if ((ack & req) != '0)
		begin
			ack_next = ack;
		end
		else
		begin
			ack_next = pick;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ack <= '0;
		end
		else
		begin
			ack <= ack_next;                      // One cycle after the request
		end
	end

endmodule

// File: logic/dcache.sv
`timescale 1ns/1ps

module dcache (
	input  logic              clk,
	input  logic              arst_n,
	input  mem_pkg::dc_cmd_t  cmd,
	output logic              wait_o,
	output mem_pkg::word_t    rd_data,
	output logic              bus_rq,
	input  logic              bus_ack,
	output mem_pkg::bus_req_t bus_out,
	input  mem_pkg::bus_rsp_t bus_in
);

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_DONE} state_t;

	state_t                          state;
	state_t                          state_next;
	mem_pkg::tag_t                   tag_arr  [mem_pkg::cache_lines];
	mem_pkg::word_t                  data_arr [mem_pkg::cache_lines];
	logic [mem_pkg::cache_lines-1:0] valid;
	mem_pkg::index_t                 idx;
	mem_pkg::tag_t                   tag;
	logic                            hit;
	logic                            need_bus;
	logic                            xfer_done;

	assign idx       = cmd.addr[mem_pkg::index_w+1:2];
	assign tag       = cmd.addr[mem_pkg::addr_w-1:mem_pkg::index_w+2];
	assign hit       = valid[idx] && (tag_arr[idx] == tag);
	assign need_bus  = cmd.wr || (cmd.rd && !hit);    // Writes always go through
	assign xfer_done = (state == S_WAIT) && bus_in.ready;

	assign bus_rq  = (state == S_REQ) || (state == S_WAIT);
	assign rd_data = data_arr[idx];                  // Hit word or the fresh line in S_DONE

	always_comb
	begin
		case (state)
			S_IDLE:  wait_o = need_bus;
			S_DONE:  wait_o = 1'b0;
			default: wait_o = 1'b1;
		endcase
	end

	always_comb
	begin
		state_next = state;
		case (state)
			S_IDLE:
			begin
				if (need_bus)
				begin
					state_next = S_REQ;
				end
			end
			S_REQ:
			begin
				if (bus_ack)
				begin
					state_next = S_WAIT;
				end
			end
			S_WAIT:
			begin
				if (bus_in.ready)
				begin
					state_next = S_DONE;
				end
			end
			S_DONE:
			begin
				state_next = S_IDLE;              // Requester moves on after this cycle
			end
			default:
			begin
				state_next = S_IDLE;
			end
		endcase
	end

	always_comb
	begin
		bus_out = '0;
		if (bus_ack)
		begin
			bus_out.addr  = cmd.addr;
			bus_out.wdata = cmd.wr ? cmd.wdata : '0;
			bus_out.rd    = (state == S_REQ) && cmd.rd;
			bus_out.wr    = (state == S_REQ) && cmd.wr;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= S_IDLE;
			valid <= '0;
		end
		else
		begin
			state <= state_next;
			if (xfer_done && !cmd.wr)
			begin
				valid[idx] <= 1'b1;               // Allocate on read miss only
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (xfer_done)
		begin
			if (cmd.wr)
			begin
				if (hit)
				begin
					data_arr[idx] <= cmd.wdata;   // Keep a hitting line current
				end
			end
			else
			begin
				tag_arr[idx]  <= tag;
				data_arr[idx] <= bus_in.rdata;
			end
		end
	end

endmodule

// File: logic/icache.sv
`timescale 1ns/1ps

module icache (
	input  logic              clk,
	input  logic              arst_n,
	input  mem_pkg::ic_cmd_t  cmd,
	output logic              wait_o,
	output mem_pkg::word_t    data,
	output logic              bus_rq,
	input  logic              bus_ack,
	output mem_pkg::bus_req_t bus_out,
	input  mem_pkg::bus_rsp_t bus_in
);

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} state_t;

	state_t                          state;
	state_t                          state_next;
	mem_pkg::tag_t                   tag_arr  [mem_pkg::cache_lines];
	mem_pkg::word_t                  data_arr [mem_pkg::cache_lines];
	logic [mem_pkg::cache_lines-1:0] valid;
	mem_pkg::index_t                 idx;
	mem_pkg::tag_t                   tag;
	logic                            hit;
	logic                            fill;

	assign idx  = cmd.addr[mem_pkg::index_w+1:2];
	assign tag  = cmd.addr[mem_pkg::addr_w-1:mem_pkg::index_w+2];
	assign hit  = valid[idx] && (tag_arr[idx] == tag);
	assign fill = (state == S_WAIT) && bus_in.ready;

	assign wait_o = cmd.req && (state != S_IDLE || !hit);
	assign bus_rq = (state != S_IDLE);

	always_comb
	begin
		state_next = state;
		case (state)
			S_IDLE:
			begin
				if (cmd.req && !hit)
				begin
					state_next = S_REQ;
				end
			end
			S_REQ:
			begin
				if (bus_ack)
				begin
					state_next = S_WAIT;              // Strobe goes out this cycle
				end
			end
			S_WAIT:
			begin
				if (bus_in.ready)
				begin
					state_next = S_IDLE;              // Retried as a hit
				end
			end
			default:
			begin
				state_next = S_IDLE;
			end
		endcase
	end

	// Nothing on the bus without the grant
	always_comb
	begin
		bus_out = '0;
		if (bus_ack)
		begin
			bus_out.addr = cmd.addr;
			bus_out.rd   = (state == S_REQ);
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= S_IDLE;
			valid <= '0;
		end
		else
		begin
			state <= state_next;
			if (fill)
			begin
				valid[idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill)
		begin
			tag_arr[idx]  <= tag;
			data_arr[idx] <= bus_in.rdata;
		end
		if (cmd.req && hit && state == S_IDLE)
		begin
			data <= data_arr[idx];                // Valid the cycle after the request
		end
	end

endmodule

// File: logic/mem_pkg.sv
package mem_pkg;

	localparam int addr_w        = 32;
	localparam int data_w        = 32;
	localparam int num_masters   = 2;
	localparam int master_dcache = 0;             // Wins ties
	localparam int master_icache = 1;
	localparam int cache_lines   = 16;            // One word per line
	localparam int index_w       = 4;             // Address bits 5..2
	localparam int tag_w         = addr_w - 6;
	localparam int ram_words     = 1024;
	localparam int ram_addr_w    = 10;            // Address bits 11..2

	typedef logic [addr_w-1:0]      addr_t;
	typedef logic [data_w-1:0]      word_t;
	typedef logic [num_masters-1:0] grant_t;
	typedef logic [index_w-1:0]     index_t;
	typedef logic [tag_w-1:0]       tag_t;

	// One master at a time on the shared bus
	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic  rd;
		logic  wr;
	} bus_req_t;

	typedef struct packed {
		word_t rdata;                             // Zero outside the ready cycle
		logic  ready;
	} bus_rsp_t;

	typedef struct packed {
		addr_t addr;
		logic  req;
	} ic_cmd_t;

	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic  rd;
		logic  wr;
	} dc_cmd_t;

endpackage

// File: logic/mem_system.sv
`timescale 1ns/1ps

module mem_system (
	input  logic             clk,
	input  logic             arst_n,
	input  mem_pkg::ic_cmd_t ic_cmd,
	output logic             ic_wait,
	output mem_pkg::word_t   ic_data,
	input  mem_pkg::dc_cmd_t dc_cmd,
	output logic             dc_wait,
	output mem_pkg::word_t   dc_rd_data
);

	mem_pkg::grant_t   arb_req;
	mem_pkg::grant_t   arb_ack;
	logic              ic_rq;
	logic              dc_rq;
	mem_pkg::bus_req_t ic_bus;
	mem_pkg::bus_req_t dc_bus;
	mem_pkg::bus_req_t bus_req;
	mem_pkg::bus_rsp_t bus_rsp;

	assign arb_req[mem_pkg::master_dcache] = dc_rq;
	assign arb_req[mem_pkg::master_icache] = ic_rq;

	// Idle masters drive zero, so OR is the bus mux
	assign bus_req = ic_bus | dc_bus;

	bus_arbiter u_arbiter (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (arb_req),
		.ack    (arb_ack)
	);

	icache u_icache (
		.clk     (clk),
		.arst_n  (arst_n),
		.cmd     (ic_cmd),
		.wait_o  (ic_wait),
		.data    (ic_data),
		.bus_rq  (ic_rq),
		.bus_ack (arb_ack[mem_pkg::master_icache]),
		.bus_out (ic_bus),
		.bus_in  (bus_rsp)
	);

	dcache u_dcache (
		.clk     (clk),
		.arst_n  (arst_n),
		.cmd     (dc_cmd),
		.wait_o  (dc_wait),
		.rd_data (dc_rd_data),
		.bus_rq  (dc_rq),
		.bus_ack (arb_ack[mem_pkg::master_dcache]),
		.bus_out (dc_bus),
		.bus_in  (bus_rsp)
	);

	block_ram u_ram (
		.clk (clk),
		.req (bus_req),
		.rsp (bus_rsp)                            // Broadcast to both caches
	);

endmodule

// File: tb.f
logic/mem_pkg.sv
logic/bus_arbiter.sv
logic/icache.sv
logic/dcache.sv
logic/block_ram.sv
logic/mem_system.sv
tb/mem_system_checker.sv
tb/tb_mem_system.sv

// File: tb/mem_system_checker.sv
`timescale 1ns/1ps

module mem_system_checker (
	input logic              clk,
	input logic              arst_n,
	input mem_pkg::grant_t   ack,
	input mem_pkg::bus_req_t bus_req,
	input mem_pkg::bus_rsp_t bus_rsp
);

	int unsigned fail_count = 0;                  // Assertion failures so far
	logic        strobe;

	assign strobe = bus_req.rd || bus_req.wr;

	assert property (@(posedge clk) disable iff (!arst_n) $onehot0(ack))
	else
	begin
		$error("Bus grant held by more than one master");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!arst_n) !(bus_req.rd && bus_req.wr))
	else
	begin
		$error("Read and write strobes high together");
		fail_count++;
	end

	// RAM answers exactly one cycle after a strobe
	assert property (@(posedge clk) disable iff (!arst_n) strobe |=> bus_rsp.ready)
	else
	begin
		$error("No ready in the cycle after a strobe");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (!arst_n) bus_rsp.ready |-> $past(strobe))
	else
	begin
		$error("Ready without a strobe in the previous cycle");
		fail_count++;
	end

endmodule

bind mem_system mem_system_checker u_checker (
	.clk     (clk),
	.arst_n  (arst_n),
	.ack     (arb_ack),
	.bus_req (bus_req),
	.bus_rsp (bus_rsp)
);

// File: tb/tb_mem_system.sv
`timescale 1ns/1ps

module tb_mem_system;

	logic             clk;
	logic             arst_n;
	mem_pkg::ic_cmd_t ic_cmd;
	logic             ic_wait;
	mem_pkg::word_t   ic_data;
	mem_pkg::dc_cmd_t dc_cmd;
	logic             dc_wait;
	mem_pkg::word_t   dc_rd_data;
	mem_pkg::word_t   rng_state      = 32'd86020;
	int               timeout_cycles = 50;       // Per wait loop
	string            test_name;
	mem_pkg::addr_t   wr_addr [6];
	mem_pkg::word_t   wr_data [6];

	mem_system DUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.ic_cmd     (ic_cmd),
		.ic_wait    (ic_wait),
		.ic_data    (ic_data),
		.dc_cmd     (dc_cmd),
		.dc_wait    (dc_wait),
		.dc_rd_data (dc_rd_data)
	);

	always #5 clk = ~clk;

	function automatic mem_pkg::word_t next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "Stopped at the first error");
	endtask

	// Bound assertions count their failures
	always @(DUT.u_checker.fail_count)
	begin
		if (DUT.u_checker.fail_count != 0)
		begin
			stop_with_error($sformatf("A bus assertion failed in %s", test_name));
		end
	end

	task automatic check_word(input string what, input mem_pkg::word_t expected,
		input mem_pkg::word_t actual);
		if (actual !== expected)
		begin
			stop_with_error($sformatf("Error in %s, %s: expected %h, actual %h",
				test_name, what, expected, actual));
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			stop_with_error($sformatf("Error in %s, %s: expected %b, actual %b",
				test_name, what, expected, actual));
		end
	endtask

	// Starts on a falling edge, returns on the falling edge after completion
	task automatic dc_access(input mem_pkg::addr_t addr, input logic write,
		input mem_pkg::word_t value, input logic expect_hit);
		int n;
		n = 0;
		dc_cmd.addr  = addr;
		dc_cmd.wdata = write ? value : '0;
		dc_cmd.rd    = !write;
		dc_cmd.wr    = write;
		#1;                                      // Sample after the inputs settle
		check_bit("dc_wait in request cycle", !expect_hit, dc_wait);
		while (dc_wait)
		begin
			if (n == timeout_cycles)
			begin
				stop_with_error($sformatf("The data port never left wait in %s", test_name));
			end
			@(negedge clk);
			#1;
			n++;
		end
		if (!write)
		begin
			check_word("dc_rd_data", value, dc_rd_data);
		end
		@(negedge clk);
	endtask

	// Leaves the fetch request high so a hit can follow at once
	task automatic ic_fetch(input mem_pkg::addr_t addr, input mem_pkg::word_t expected,
		input logic expect_hit);
		int n;
		n = 0;
		ic_cmd.addr = addr;
		ic_cmd.req  = 1'b1;
		#1;
		check_bit("ic_wait in request cycle", !expect_hit, ic_wait);
		while (ic_wait)
		begin
			if (n == timeout_cycles)
			begin
				stop_with_error($sformatf("The fetch port never left wait in %s", test_name));
			end
			@(negedge clk);
			#1;
			n++;
		end
		@(negedge clk);
		check_word("ic_data", expected, ic_data);  // Registered one cycle later
	endtask

	task automatic idle_ports();
		ic_cmd = '0;
		dc_cmd = '0;
		@(negedge clk);
	endtask

	task automatic idle_after_reset();
		test_name = "reset";
		#1;
		check_bit("ic_wait", 1'b0, ic_wait);
		check_bit("dc_wait", 1'b0, dc_wait);
		@(negedge clk);
	endtask

	task automatic write_then_read();
		test_name = "write_read";
		for (int i = 0; i < 6; i++)
		begin
			wr_addr[i] = 32'h100 + 4 * i;          // Lines 0 to 5
			wr_data[i] = next_random();
			dc_access(wr_addr[i], 1'b1, wr_data[i], 1'b0);
		end
		for (int i = 0; i < 6; i++)
		begin
			dc_access(wr_addr[i], 1'b0, wr_data[i], 1'b0);  // Writes do not allocate
		end
		for (int i = 0; i < 6; i++)
		begin
			dc_access(wr_addr[i], 1'b0, wr_data[i], 1'b1);
		end
		idle_ports();
	endtask

	task automatic fetch_miss_then_hit();
		test_name = "fetch";
		ic_fetch(wr_addr[2], wr_data[2], 1'b0);
		ic_fetch(wr_addr[2], wr_data[2], 1'b1);
		idle_ports();
	endtask

	task automatic evict_and_refill();
		mem_pkg::word_t value_a;
		mem_pkg::word_t value_b;
		value_a = next_random();
		value_b = next_random();
		test_name = "eviction";
		dc_access(wr_addr[0], 1'b1, value_a, 1'b0);  // Hits the cached line
		wr_data[0] = value_a;
		dc_access(wr_addr[0], 1'b0, value_a, 1'b1);
		dc_access(32'h500, 1'b1, value_b, 1'b0);     // Same index but another tag
		dc_access(32'h500, 1'b0, value_b, 1'b0);
		dc_access(wr_addr[0], 1'b0, value_a, 1'b0);  // Refill from RAM
		idle_ports();
	endtask

	task automatic fetch_and_load_together();
		mem_pkg::word_t value_c;
		value_c = next_random();
		test_name = "contention";
		dc_access(32'h718, 1'b1, value_c, 1'b0);
		fork
			ic_fetch(wr_addr[3], wr_data[3], 1'b0);
			dc_access(32'h718, 1'b0, value_c, 1'b0);
		join
		idle_ports();
	endtask

	initial
	begin
		clk    = 1'b0;
		arst_n = 1'b0;
		ic_cmd = '0;
		dc_cmd = '0;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		idle_after_reset();
		write_then_read();
		fetch_miss_then_hit();
		evict_and_refill();
		fetch_and_load_together();
		$display("All checks passed");
		$finish;
	end

endmodule
